// File: rv_pkg.sv
// Shared widths, opcodes, ALU operator codes and instruction word views for the execution slice
package rv_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Data and address width
  localparam int XLEN           = 32;
  // Register index width
  localparam int REG_ADDR_WIDTH = 5;
  // CSR address width
  localparam int CSR_ADDR_WIDTH = 12;

  ////////////////////////////////////////////////////////////
  // Major opcodes
  ////////////////////////////////////////////////////////////

  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_OPIMM  = 7'h13;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_JAL    = 7'h6f;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_SYSTEM = 7'h73;

  ////////////////////////////////////////////////////////////
  // ALU operators
  ////////////////////////////////////////////////////////////

  // Compare codes drive comparison_result of the ALU
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    ALU_EQ   = 4'd7,
    ALU_NE   = 4'd8,
    ALU_LT   = 4'd9
  } alu_op_e;

  ////////////////////////////////////////////////////////////
  // Instruction word
  ////////////////////////////////////////////////////////////

  // Same 32 bits seen as R format or as I format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } instr_u;

endpackage

// File: rv_id_ex_if.sv
// ID/EX bundle carrying the decoded operation and operands from decode to execute
interface rv_id_ex_if import rv_pkg::*; ();

  // Item present in execute
  logic                      valid;
  alu_op_e                   alu_op;
  logic [XLEN-1:0]           operand_a;
  logic [XLEN-1:0]           operand_b;
  // Return address for JAL, branch target for branches
  logic [XLEN-1:0]           operand_c;
  logic [REG_ADDR_WIDTH-1:0] rd;
  // Write through the forwarding path
  logic                      alu_we;
  logic                      csr_read;
  logic [CSR_ADDR_WIDTH-1:0] csr_addr;
  logic                      branch;
  logic                      jal;
  // Execute holds the item, decode must not overwrite it
  logic                      stall;

  modport dec (
    output valid, alu_op, operand_a, operand_b, operand_c, rd,
    output alu_we, csr_read, csr_addr, branch, jal,
    input  stall
  );

  modport ex (
    input  valid, alu_op, operand_a, operand_b, operand_c, rd,
    input  alu_we, csr_read, csr_addr, branch, jal,
    output stall
  );

endinterface

// File: rv_regfile.sv
// Integer register file, 32 entries of XLEN bits, two async read ports and one write port
module rv_regfile import rv_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [REG_ADDR_WIDTH-1:0] raddr_a_i,
  input  logic [REG_ADDR_WIDTH-1:0] raddr_b_i,
  output logic [XLEN-1:0]           rdata_a_o,
  output logic [XLEN-1:0]           rdata_b_o,
  input  logic                      we_i,
  input  logic [REG_ADDR_WIDTH-1:0] waddr_i,
  input  logic [XLEN-1:0]           wdata_i
);

  // x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int n = 1; n < 32; n++)
      begin
        regs[n] <= '0;
      end
    end
    else if (we_i && (waddr_i != '0))
    begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Async reads, no bypass of a same-cycle write
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

// File: rv_decoder.sv
// Decode stage: field decode, operand build and the ID/EX register
module rv_decoder import rv_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      instr_valid_i,
  input  instr_u                    instr_i,
  input  logic [XLEN-1:0]           instr_pc_i,
  output logic [REG_ADDR_WIDTH-1:0] rs1_addr_o,
  output logic [REG_ADDR_WIDTH-1:0] rs2_addr_o,
  input  logic [XLEN-1:0]           rs1_data_i,
  input  logic [XLEN-1:0]           rs2_data_i,
  rv_id_ex_if.dec                   id_ex
);

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_b;
  alu_op_e         dec_op;
  logic [XLEN-1:0] dec_a;
  logic [XLEN-1:0] dec_b;
  logic [XLEN-1:0] dec_c;
  logic            dec_known;
  logic            dec_we;
  logic            dec_csr;
  logic            dec_branch;
  logic            dec_jal;

  // Register indices sit at the same place in every format
  assign rs1_addr_o = instr_i.r.rs1;
  assign rs2_addr_o = instr_i.r.rs2;

  ////////////////////////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////////////////////////

  // I and U immediates come from the I view
  assign imm_i = {{(XLEN-12){instr_i.i.imm[11]}}, instr_i.i.imm};
  assign imm_u = {instr_i.i.imm, instr_i.i.rs1, instr_i.i.funct3, 12'h000};
  // J immediate, bits 19:12 of the word are rs1 and funct3
  assign imm_j = {{(XLEN-20){instr_i.i.imm[11]}}, instr_i.i.rs1, instr_i.i.funct3,
                  instr_i.i.imm[0], instr_i.i.imm[10:1], 1'b0};
  // B immediate is split across funct7 and rd of the R view
  assign imm_b = {{(XLEN-12){instr_i.r.funct7[6]}}, instr_i.r.rd[0],
                  instr_i.r.funct7[5:0], instr_i.r.rd[4:1], 1'b0};

  ////////////////////////////////////////////////////////////
  // Operation decode
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    dec_op     = ALU_ADD;
    dec_a      = rs1_data_i;
    dec_b      = rs2_data_i;
    dec_c      = instr_pc_i + imm_b;
    dec_known  = 1'b1;
    dec_we     = 1'b0;
    dec_csr    = 1'b0;
    dec_branch = 1'b0;
    dec_jal    = 1'b0;
    case (instr_i.r.opcode)
      OPC_OP, OPC_OPIMM:
      begin
        dec_we = 1'b1;
        // Immediate replaces rs2 for OP-IMM
        if (instr_i.r.opcode == OPC_OPIMM)
        begin
          dec_b = imm_i;
        end
        case (instr_i.r.funct3)
          3'b000:
          begin
            // Only register form can subtract
            if ((instr_i.r.opcode == OPC_OP) && instr_i.r.funct7[5])
            begin
              dec_op = ALU_SUB;
            end
          end
          3'b010:  dec_op = ALU_SLT;
          3'b011:  dec_op = ALU_SLTU;
          3'b100:  dec_op = ALU_XOR;
          3'b110:  dec_op = ALU_OR;
          3'b111:  dec_op = ALU_AND;
          // Shifts are not supported
          default: dec_known = 1'b0;
        endcase
      end
      OPC_LUI:
      begin
        dec_we = 1'b1;
        dec_a  = '0;
        dec_b  = imm_u;
      end
      OPC_JAL:
      begin
        // Adder forms the target, operand c the link value
        dec_we  = 1'b1;
        dec_jal = 1'b1;
        dec_a   = instr_pc_i;
        dec_b   = imm_j;
        dec_c   = instr_pc_i + 4;
      end
      OPC_BRANCH:
      begin
        dec_branch = 1'b1;
        case (instr_i.r.funct3)
          3'b000:  dec_op = ALU_EQ;
          3'b001:  dec_op = ALU_NE;
          3'b100:  dec_op = ALU_LT;
          default: dec_known = 1'b0;
        endcase
      end
      OPC_SYSTEM:
      begin
        // CSRRS read form only, no CSR side effects
        dec_csr   = (instr_i.i.funct3 == 3'b010);
        dec_known = dec_csr;
      end
      default: dec_known = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////////////////////////

  // Control part, unknown words turn into a bubble
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      id_ex.valid    <= 1'b0;
      id_ex.alu_we   <= 1'b0;
      id_ex.csr_read <= 1'b0;
      id_ex.branch   <= 1'b0;
      id_ex.jal      <= 1'b0;
    end
    else if (!id_ex.stall)
    begin
      id_ex.valid    <= instr_valid_i && dec_known;
      id_ex.alu_we   <= instr_valid_i && dec_known && dec_we;
      id_ex.csr_read <= instr_valid_i && dec_known && dec_csr;
      id_ex.branch   <= instr_valid_i && dec_known && dec_branch;
      id_ex.jal      <= instr_valid_i && dec_known && dec_jal;
    end
  end

  // Payload part
  always_ff @(posedge clk)
  begin
    if (instr_valid_i && !id_ex.stall)
    begin
      id_ex.alu_op    <= dec_op;
      id_ex.operand_a <= dec_a;
      id_ex.operand_b <= dec_b;
      id_ex.operand_c <= dec_c;
      id_ex.rd        <= instr_i.r.rd;
      id_ex.csr_addr  <= instr_i.i.imm;
    end
  end

endmodule

// File: rv_alu.sv
// Single-cycle ALU: shared adder/subtractor, logic ops and signed/unsigned compares
module rv_alu import rv_pkg::*; (
  input  alu_op_e         operator_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  output logic [XLEN-1:0] adder_result_o,
  output logic [XLEN-1:0] result_o,
  output logic            comparison_result_o
);

  logic            is_sub;
  logic [XLEN-1:0] adder_b;
  logic            is_equal;
  logic            less_signed;
  logic            less_unsigned;

  ////////////////////////////////////////////////////////////
  // Adder
  ////////////////////////////////////////////////////////////

  // Two's complement subtract through the same adder
  assign is_sub         = (operator_i == ALU_SUB);
  assign adder_b        = is_sub ? ~operand_b_i : operand_b_i;
  assign adder_result_o = operand_a_i + adder_b + {{(XLEN-1){1'b0}}, is_sub};

  ////////////////////////////////////////////////////////////
  // Compares
  ////////////////////////////////////////////////////////////

  assign is_equal      = (operand_a_i == operand_b_i);
  assign less_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign less_unsigned = (operand_a_i < operand_b_i);

  always_comb
  begin
    case (operator_i)
      ALU_EQ:          comparison_result_o = is_equal;
      ALU_NE:          comparison_result_o = !is_equal;
      ALU_LT, ALU_SLT: comparison_result_o = less_signed;
      ALU_SLTU:        comparison_result_o = less_unsigned;
      default:         comparison_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    case (operator_i)
      ALU_AND:           result_o = operand_a_i & operand_b_i;
      ALU_OR:            result_o = operand_a_i | operand_b_i;
      ALU_XOR:           result_o = operand_a_i ^ operand_b_i;
      // Set-less-than, zero extended flag
      ALU_SLT, ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, comparison_result_o};
      default:           result_o = adder_result_o;
    endcase
  end

endmodule

// File: rv_ex_stage.sv
// Execute stage: ALU, result select, CSR request, branch outputs, EX/WB register and stall
module rv_ex_stage import rv_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  rv_id_ex_if.ex                    id_ex,
  input  logic                      csr_pending_i,
  output logic                      fw_we_o,
  output logic [REG_ADDR_WIDTH-1:0] fw_waddr_o,
  output logic [XLEN-1:0]           fw_wdata_o,
  output logic                      csr_req_o,
  output logic [CSR_ADDR_WIDTH-1:0] csr_addr_o,
  output logic                      wb_we_o,
  output logic [REG_ADDR_WIDTH-1:0] wb_waddr_o,
  output logic [XLEN-1:0]           jump_target_o,
  output logic                      branch_decision_o,
  output logic                      branch_valid_o
);

  logic [XLEN-1:0] alu_adder;
  logic [XLEN-1:0] alu_result;
  logic            alu_cmp;
  logic            ex_leave;

  rv_alu alu_i (
    .operator_i          (id_ex.alu_op),
    .operand_a_i         (id_ex.operand_a),
    .operand_b_i         (id_ex.operand_b),
    .adder_result_o      (alu_adder),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp)
  );

  // Register port taken by a pending CSR write, a writing item has to wait
  assign id_ex.stall = id_ex.valid && id_ex.alu_we && csr_pending_i;
  assign ex_leave    = id_ex.valid && !id_ex.stall;

  // Forwarding path, link value for JAL
  assign fw_we_o    = ex_leave && id_ex.alu_we;
  assign fw_waddr_o = id_ex.rd;
  assign fw_wdata_o = id_ex.jal ? id_ex.operand_c : alu_result;

  // CSR read request, data comes back next cycle
  assign csr_req_o  = id_ex.valid && id_ex.csr_read;
  assign csr_addr_o = id_ex.csr_addr;

  ////////////////////////////////////////////////////////////
  // Branch and jump
  ////////////////////////////////////////////////////////////

  // Branch target was built in decode, JAL target from the adder
  assign jump_target_o     = id_ex.branch ? id_ex.operand_c : alu_adder;
  assign branch_decision_o = id_ex.jal || alu_cmp;
  assign branch_valid_o    = ex_leave && (id_ex.branch || id_ex.jal);

  ////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////

  // Only CSR reads travel on, empty otherwise
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_we_o    <= 1'b0;
      wb_waddr_o <= '0;
    end
    else
    begin
      wb_we_o <= ex_leave && id_ex.csr_read;
      if (ex_leave && id_ex.csr_read)
      begin
        wb_waddr_o <= id_ex.rd;
      end
    end
  end

endmodule

// File: rv_wb_stage.sv
// Writeback stage: owns the register-file write port, CSR data against EX forwarding
module rv_wb_stage import rv_pkg::*; (
  input  logic                      fw_we_i,
  input  logic [REG_ADDR_WIDTH-1:0] fw_waddr_i,
  input  logic [XLEN-1:0]           fw_wdata_i,
  input  logic                      wb_we_i,
  input  logic [REG_ADDR_WIDTH-1:0] wb_waddr_i,
  input  logic [XLEN-1:0]           csr_rdata_i,
  output logic                      csr_pending_o,
  output logic                      rf_we_o,
  output logic [REG_ADDR_WIDTH-1:0] rf_waddr_o,
  output logic [XLEN-1:0]           rf_wdata_o
);

  // Tells execute the port is taken this cycle
  assign csr_pending_o = wb_we_i;

  ////////////////////////////////////////////////////////////
  // Port arbitration
  ////////////////////////////////////////////////////////////

  // Execute drops its enable on a clash, so one source at most is active
  always_comb
  begin
    if (wb_we_i)
    begin
      // CSR read data arrives in this cycle
      rf_we_o    = 1'b1;
      rf_waddr_o = wb_waddr_i;
      rf_wdata_o = csr_rdata_i;
    end
    else
    begin
      rf_we_o    = fw_we_i;
      rf_waddr_o = fw_waddr_i;
      rf_wdata_o = fw_wdata_i;
    end
  end

endmodule

// File: rv_core_top.sv
// Execution slice top level: register file, decode, execute and writeback on plain ports
module rv_core_top import rv_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      instr_valid_i,
  input  logic [XLEN-1:0]           instr_i,
  input  logic [XLEN-1:0]           instr_pc_i,
  output logic                      ready_o,
  output logic                      csr_req_o,
  output logic [CSR_ADDR_WIDTH-1:0] csr_addr_o,
  input  logic [XLEN-1:0]           csr_rdata_i,
  output logic                      rf_we_o,
  output logic [REG_ADDR_WIDTH-1:0] rf_waddr_o,
  output logic [XLEN-1:0]           rf_wdata_o,
  output logic                      branch_valid_o,
  output logic                      branch_decision_o,
  output logic [XLEN-1:0]           jump_target_o
);

  logic [REG_ADDR_WIDTH-1:0] rs1_addr;
  logic [REG_ADDR_WIDTH-1:0] rs2_addr;
  logic [XLEN-1:0]           rs1_data;
  logic [XLEN-1:0]           rs2_data;
  logic                      fw_we;
  logic [REG_ADDR_WIDTH-1:0] fw_waddr;
  logic [XLEN-1:0]           fw_wdata;
  logic                      wb_we;
  logic [REG_ADDR_WIDTH-1:0] wb_waddr;
  logic                      csr_pending;

  rv_id_ex_if id_ex ();

  // Issue accepted only while execute is free
  assign ready_o = !id_ex.stall;

  rv_regfile regfile_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (rs1_addr),
    .raddr_b_i (rs2_addr),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data),
    .we_i      (rf_we_o),
    .waddr_i   (rf_waddr_o),
    .wdata_i   (rf_wdata_o)
  );

  rv_decoder decoder_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_pc_i    (instr_pc_i),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .id_ex         (id_ex.dec)
  );

  rv_ex_stage ex_stage_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .id_ex             (id_ex.ex),
    .csr_pending_i     (csr_pending),
    .fw_we_o           (fw_we),
    .fw_waddr_o        (fw_waddr),
    .fw_wdata_o        (fw_wdata),
    .csr_req_o         (csr_req_o),
    .csr_addr_o        (csr_addr_o),
    .wb_we_o           (wb_we),
    .wb_waddr_o        (wb_waddr),
    .jump_target_o     (jump_target_o),
    .branch_decision_o (branch_decision_o),
    .branch_valid_o    (branch_valid_o)
  );

  rv_wb_stage wb_stage_i (
    .fw_we_i       (fw_we),
    .fw_waddr_i    (fw_waddr),
    .fw_wdata_i    (fw_wdata),
    .wb_we_i       (wb_we),
    .wb_waddr_i    (wb_waddr),
    .csr_rdata_i   (csr_rdata_i),
    .csr_pending_o (csr_pending),
    .rf_we_o       (rf_we_o),
    .rf_waddr_o    (rf_waddr_o),
    .rf_wdata_o    (rf_wdata_o)
  );

endmodule

// File: tb_rv_core_assert.sv
// Bound checker with a shadow register file, an expected pipeline and port assertions
module tb_rv_core_assert import rv_pkg::*; (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      instr_valid_i,
  input logic [XLEN-1:0]           instr_i,
  input logic [XLEN-1:0]           instr_pc_i,
  input logic                      ready_o,
  input logic                      csr_req_o,
  input logic [CSR_ADDR_WIDTH-1:0] csr_addr_o,
  input logic [XLEN-1:0]           csr_rdata_i,
  input logic                      rf_we_o,
  input logic [REG_ADDR_WIDTH-1:0] rf_waddr_o,
  input logic [XLEN-1:0]           rf_wdata_o,
  input logic                      branch_valid_o,
  input logic                      branch_decision_o,
  input logic [XLEN-1:0]           jump_target_o
);

  // Shadow copy of the architectural registers where x0 is never written
  logic [XLEN-1:0] shadow [0:31];

  // Expected execute slot and CSR write-back slot
  logic                      ex_v;
  logic                      ex_we;
  logic                      ex_csr;
  logic                      ex_br;
  logic                      ex_dec;
  logic [REG_ADDR_WIDTH-1:0] ex_rd;
  logic [XLEN-1:0]           ex_data;
  logic [XLEN-1:0]           ex_target;
  logic [CSR_ADDR_WIDTH-1:0] ex_caddr;
  logic                      wb_v;
  logic [REG_ADDR_WIDTH-1:0] wb_rd;

  // Reference decode of the word on the issue port
  instr_u          w;
  logic [XLEN-1:0] ra;
  logic [XLEN-1:0] rb;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] d_data;
  logic [XLEN-1:0] d_target;
  logic            d_v;
  logic            d_we;
  logic            d_csr;
  logic            d_br;
  logic            d_dec;

  // Expected port behavior in this cycle
  logic                      exp_stall;
  logic                      exp_we;
  logic                      exp_bv;
  logic                      exp_req;
  logic [REG_ADDR_WIDTH-1:0] exp_waddr;
  logic [XLEN-1:0]           exp_wdata;

  // One flag per assertion for the testbench top
  logic fail_ready = 1'b0;
  logic fail_we    = 1'b0;
  logic fail_wdata = 1'b0;
  logic fail_csr   = 1'b0;
  logic fail_bv    = 1'b0;
  logic fail_tgt   = 1'b0;
  logic fired;

  assign fired = fail_ready | fail_we | fail_wdata | fail_csr | fail_bv | fail_tgt;

  assign w     = instr_i;
  assign ra    = shadow[w.r.rs1];
  assign rb    = shadow[w.r.rs2];
  assign imm_i = {{20{w.i.imm[11]}}, w.i.imm};

  ////////////////////////////////////////////////////////////
  // ISA reference decode
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    d_v      = 1'b1;
    d_we     = 1'b0;
    d_csr    = 1'b0;
    d_br     = 1'b0;
    d_dec    = 1'b0;
    d_data   = '0;
    d_target = '0;
    case (w.r.opcode)
      OPC_OP, OPC_OPIMM:
      begin
        d_we = 1'b1;
      end
      OPC_LUI:
      begin
        d_we   = 1'b1;
        d_data = {instr_i[31:12], 12'h000};
      end
      OPC_JAL:
      begin
        d_we     = 1'b1;
        d_br     = 1'b1;
        d_dec    = 1'b1;
        d_data   = instr_pc_i + 32'd4;
        d_target = instr_pc_i + {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                                 instr_i[30:21], 1'b0};
      end
      OPC_BRANCH:
      begin
        d_br     = 1'b1;
        d_target = instr_pc_i + {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                                 instr_i[11:8], 1'b0};
        case (w.r.funct3)
          3'b000:  d_dec = (ra == rb);
          3'b001:  d_dec = (ra != rb);
          3'b100:  d_dec = ($signed(ra) < $signed(rb));
          default: d_v = 1'b0;
        endcase
      end
      OPC_SYSTEM:  d_csr = 1'b1;
      default:     d_v = 1'b0;
    endcase
  end

  // Arithmetic result for register and immediate forms
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] arith;

  assign op_b = (w.r.opcode == OPC_OPIMM) ? imm_i : rb;

  always_comb
  begin
    case (w.r.funct3)
      3'b000:  arith = ((w.r.opcode == OPC_OP) && w.r.funct7[5]) ? ra - op_b : ra + op_b;
      3'b010:  arith = {31'b0, $signed(ra) < $signed(op_b)};
      3'b011:  arith = {31'b0, ra < op_b};
      3'b100:  arith = ra ^ op_b;
      3'b110:  arith = ra | op_b;
      default: arith = ra & op_b;
    endcase
  end

  // CSR read data owns the port and a writing execute item waits
  assign exp_stall = ex_v && ex_we && wb_v;
  assign exp_we    = wb_v || (ex_v && ex_we);
  assign exp_waddr = wb_v ? wb_rd : ex_rd;
  assign exp_wdata = wb_v ? csr_rdata_i : ex_data;
  assign exp_bv    = ex_v && ex_br && !exp_stall;
  assign exp_req   = ex_v && ex_csr;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int n = 0; n < 32; n++)
      begin
        shadow[n] <= '0;
      end
      ex_v  <= 1'b0;
      ex_we <= 1'b0;
      wb_v  <= 1'b0;
      wb_rd <= '0;
    end
    else
    begin
      if (exp_we && (exp_waddr != '0))
      begin
        shadow[exp_waddr] <= exp_wdata;
      end
      wb_v  <= ex_v && ex_csr;
      wb_rd <= ex_rd;
      if (!exp_stall)
      begin
        ex_v      <= instr_valid_i && d_v;
        ex_we     <= d_we;
        ex_csr    <= d_csr;
        ex_br     <= d_br;
        ex_dec    <= d_dec;
        ex_rd     <= w.r.rd;
        ex_data   <= ((w.r.opcode == OPC_OP) || (w.r.opcode == OPC_OPIMM)) ? arith : d_data;
        ex_target <= d_target;
        ex_caddr  <= w.i.imm;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Port assertions
  ////////////////////////////////////////////////////////////

  a_ready: assert property (@(posedge clk) disable iff (!rst_n) ready_o == !exp_stall)
    else begin
      fail_ready = 1'b1;
      $error("ERROR %0t ready_o got %b exp %b", $time, ready_o, !exp_stall);
    end

  a_we: assert property (@(posedge clk) disable iff (!rst_n) rf_we_o == exp_we)
    else begin
      fail_we = 1'b1;
      $error("ERROR %0t rf_we_o got %b exp %b", $time, rf_we_o, exp_we);
    end

  a_wdata: assert property (@(posedge clk) disable iff (!rst_n)
    exp_we |-> (rf_waddr_o == exp_waddr) && (rf_wdata_o == exp_wdata))
    else begin
      fail_wdata = 1'b1;
      $error("ERROR %0t rf_waddr_o/rf_wdata_o got %0d/%h exp %0d/%h", $time,
             rf_waddr_o, rf_wdata_o, exp_waddr, exp_wdata);
    end

  a_csr: assert property (@(posedge clk) disable iff (!rst_n)
    (csr_req_o == exp_req) && (!exp_req || (csr_addr_o == ex_caddr)))
    else begin
      fail_csr = 1'b1;
      $error("ERROR %0t csr_req_o/csr_addr_o got %b/%h exp %b/%h", $time,
             csr_req_o, csr_addr_o, exp_req, ex_caddr);
    end

  a_bv: assert property (@(posedge clk) disable iff (!rst_n) branch_valid_o == exp_bv)
    else begin
      fail_bv = 1'b1;
      $error("ERROR %0t branch_valid_o got %b exp %b", $time, branch_valid_o, exp_bv);
    end

  a_tgt: assert property (@(posedge clk) disable iff (!rst_n)
    exp_bv |-> (jump_target_o == ex_target) && (branch_decision_o == ex_dec))
    else begin
      fail_tgt = 1'b1;
      $error("ERROR %0t jump_target_o/branch_decision_o got %h/%b exp %h/%b", $time,
             jump_target_o, branch_decision_o, ex_target, ex_dec);
    end

endmodule

bind rv_core_top tb_rv_core_assert checker_i (.*);

// File: tb_rv_core.sv
// Testbench for the execution slice with directed and random issue and a CSR responder
module tb_rv_core import rv_pkg::*;;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      instr_valid_i;
  logic [XLEN-1:0]           instr_i;
  logic [XLEN-1:0]           instr_pc_i;
  logic                      ready_o;
  logic                      csr_req_o;
  logic [CSR_ADDR_WIDTH-1:0] csr_addr_o;
  logic [XLEN-1:0]           csr_rdata_i = '0;
  logic                      rf_we_o;
  logic [REG_ADDR_WIDTH-1:0] rf_waddr_o;
  logic [XLEN-1:0]           rf_wdata_o;
  logic                      branch_valid_o;
  logic                      branch_decision_o;
  logic [XLEN-1:0]           jump_target_o;

  int              cyc = 0;
  int              busy_until [0:31];
  int              seed;
  logic [XLEN-1:0] pc;
  logic [11:0]     csr_addr_q = '0;

  rv_core_top rv_core_top_i (.*);

  initial
  begin
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // CSR file model answers one cycle after the request
  always @(posedge clk)
  begin
    if (csr_req_o)
    begin
      csr_addr_q <= csr_addr_o;
    end
  end

  always @(negedge clk) csr_rdata_i <= {20'h0, csr_addr_q} ^ 32'h5a5a_0c3c;

  // Stop at the first assertion that fires
  always @(posedge clk)
  begin
    if (rv_core_top_i.checker_i.fired)
    begin
      $display("Simulation finished: FAIL");
      $fatal(1, "Assertion in the bound checker failed");
    end
  end

  ////////////////////////////////////////////////////////////
  // Instruction encoders
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  // Supported funct3 codes of the integer ops
  function automatic logic [2:0] alu_f3(logic [2:0] idx);
    case (idx % 6)
      0:       return 3'b000;
      1:       return 3'b010;
      2:       return 3'b011;
      3:       return 3'b100;
      4:       return 3'b110;
      default: return 3'b111;
    endcase
  endfunction

  // Offer one word once its sources are settled and execute is free
  task automatic issue(input logic [31:0] word);
    int n;
    n = 0;
    while ((cyc < busy_until[word[19:15]]) || (cyc < busy_until[word[24:20]]) || !ready_o)
    begin
      if (n > 50)
      begin
        $display("Simulation finished: FAIL");
        $fatal(1, "Timeout waiting to issue an instruction");
      end
      @(negedge clk);
      n++;
    end
    instr_valid_i = 1'b1;
    instr_i       = word;
    instr_pc_i    = pc;
    @(negedge clk);
    instr_valid_i = 1'b0;
    pc            = pc + 32'd4;
    busy_until[word[11:7]] = cyc + 6;
  endtask

  initial
  begin
    logic [31:0] r;
    logic [2:0]  f3;
    rst_n         = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    instr_pc_i    = '0;
    pc            = 32'h0000_1000;
    seed          = 32'hca95_daf9;
    for (int n = 0; n < 32; n++)
    begin
      busy_until[n] = 0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Constants
    issue(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OPC_OPIMM));
    issue(enc_i(12'hffd, 5'd0, 3'b000, 5'd2, OPC_OPIMM));
    issue(enc_i(12'h7ff, 5'd0, 3'b000, 5'd3, OPC_OPIMM));
    issue(enc_i(12'h123, 5'd0, 3'b000, 5'd4, OPC_OPIMM));
    // Register forms
    issue(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd5));
    issue(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd6));
    issue(enc_r(7'h00, 5'd4, 5'd3, 3'b111, 5'd7));
    issue(enc_r(7'h00, 5'd4, 5'd3, 3'b110, 5'd8));
    issue(enc_r(7'h00, 5'd4, 5'd3, 3'b100, 5'd9));
    issue(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd10));
    issue(enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd11));
    issue(enc_i(12'h800, 5'd1, 3'b011, 5'd19, OPC_OPIMM));
    issue(enc_i(12'h0f0, 5'd3, 3'b100, 5'd20, OPC_OPIMM));
    // Upper immediate and jumps
    issue({20'habcde, 5'd12, OPC_LUI});
    issue(enc_j(21'h000100, 5'd13));
    issue(enc_j(21'h1ffff0, 5'd21));
    // Taken and not-taken branches
    issue(enc_b(13'h0040, 5'd1, 5'd1, 3'b000));
    issue(enc_b(13'h1ff8, 5'd2, 5'd1, 3'b000));
    issue(enc_b(13'h0020, 5'd2, 5'd1, 3'b001));
    issue(enc_b(13'h0010, 5'd1, 5'd2, 3'b100));
    issue(enc_b(13'h0010, 5'd2, 5'd1, 3'b100));
    // CSR reads followed straight away by ALU writes
    issue(enc_i(12'h300, 5'd0, 3'b010, 5'd14, OPC_SYSTEM));
    issue(enc_i(12'd7, 5'd0, 3'b000, 5'd15, OPC_OPIMM));
    issue(enc_i(12'hc00, 5'd0, 3'b010, 5'd16, OPC_SYSTEM));
    issue(enc_r(7'h00, 5'd4, 5'd3, 3'b000, 5'd17));
    // x0 stays zero
    issue(enc_i(12'd9, 5'd1, 3'b000, 5'd0, OPC_OPIMM));
    issue(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd18));

    // Random phase
    for (int k = 0; k < 200; k++)
    begin
      r  = $random(seed);
      f3 = alu_f3(r[31:29]);
      case (r[2:0])
        3'd0, 3'd1, 3'd7:
          issue(enc_r((f3 == 3'b000) ? {1'b0, r[3], 5'b0} : 7'h00, r[24:20], r[19:15], f3,
                      r[11:7]));
        3'd2: issue(enc_i(r[31:20], r[19:15], f3, r[11:7], OPC_OPIMM));
        3'd3: issue({r[31:12], r[11:7], OPC_LUI});
        3'd4: issue(enc_j({r[31:12], 1'b0}, r[11:7]));
        3'd5: issue(enc_b({r[31:20], 1'b0}, r[24:20], r[19:15],
                          (r[6:5] == 2'd0) ? 3'b000 : (r[6:5] == 2'd1) ? 3'b001 : 3'b100));
        default: issue(enc_i(r[31:20], 5'd0, 3'b010, r[11:7], OPC_SYSTEM));
      endcase
    end

    // Let the last writes drain
    repeat (8) @(negedge clk);
    if (rv_core_top_i.checker_i.fired)
    begin
      $display("Simulation finished: FAIL");
      $fatal(1, "Assertion in the bound checker failed");
    end
    else
    begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

// File: project.f
rv_pkg.sv
rv_id_ex_if.sv
rv_regfile.sv
rv_decoder.sv
rv_alu.sv
rv_ex_stage.sv
rv_wb_stage.sv
rv_core_top.sv
tb_rv_core_assert.sv
tb_rv_core.sv

// File: run.sh
#!/bin/sh
set -e
verilator --binary --timing --assert --top-module tb_rv_core -f project.f -o sim_rv_core
./obj_dir/sim_rv_core +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
  exit 1
fi
exit 0
